/* tmu_pkg.sv */
// Shared constants, CSR map, enums and payload structs for the pixel back end; import in each module
package tmu_pkg;

	localparam int LANES       = 4;             // Decay lanes in the generate loop
	localparam int LANE_DEPTH  = 2;             // Entries per lane buffer, also initial credits
	localparam int ADDR_W      = 24;            // Destination address in 16-bit pixels
	localparam int WORD_ADDR_W = ADDR_W - 2;    // Four pixels per 64-bit word
	localparam int CNT_W       = 20;            // Pixel count per run

	localparam int LANE_W      = $clog2(LANES);          // Round-robin pointer
	localparam int CREDIT_W    = $clog2(LANE_DEPTH + 1); // Holds 0..LANE_DEPTH
	localparam int BUF_PTR_W   = $clog2(LANE_DEPTH);     // Buffer read/write index

	localparam logic [3:0] CSR_BLOCK = 4'h0;    // csr_a bits 13:10 for this unit

	// CSR word offsets
	typedef enum logic [1:0] {
		CTL        = 2'd0,                      // Bit 0 start/busy, bit 1 chroma key enable
		BRIGHTNESS = 2'd1,                      // 6-bit decay factor
		CHROMA_KEY = 2'd2,                      // RGB565 key colour
		PIX_COUNT  = 2'd3                       // Pixels in the next run
	} csr_reg_e;

	// Run sequencer
	typedef enum logic [2:0] {
		IDLE,                                   // Waiting for start
		ADMIT,                                  // Taking pixels until count reached
		DRAIN,                                  // Waiting for lanes to empty
		FLUSH,                                  // Push out partial word
		WAIT_FLUSH                              // Wait for last write, then irq
	} ctl_state_e;

	// Source texel with its destination
	typedef struct packed {
		logic [15:0]       pix;                 // RGB565
		logic [ADDR_W-1:0] addr;                // Pixel address
	} pixel_in_t;

	// Lane result handed to the collector
	typedef struct packed {
		logic              keep;                // Cleared by chroma key match
		logic [15:0]       pix;                 // Decayed RGB565
		logic [ADDR_W-1:0] addr;
	} pixel_out_t;

	// One single-beat framebuffer write
	typedef struct packed {
		logic [WORD_ADDR_W-1:0] addr;           // 64-bit word address
		logic [7:0]             sel;            // Byte enables, two per pixel
		logic [63:0]            data;           // Pixel k in bits 16k+15:16k
	} mem_wr_t;

endpackage

/* tmu_ctlif.sv */
// CSR register file and run sequencer of the pixel back end; sets up a run and raises irq at its end
`timescale 1ns/10ps

module tmu_ctlif (
	input  logic        sys_clk,
	input  logic        sys_rst,
	input  logic [13:0] csr_a_i,        // Block in 13:10, word offset below
	input  logic        csr_we_i,
	input  logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,       // Registered read data
	output logic        irq_o,          // One pulse per finished run
	output logic        admit_o,        // Dispatcher may take pixels
	input  logic        accept_i,       // A pixel entered the lanes
	input  logic        retire_i,       // A pixel left the lanes
	output logic        flush_o,        // Push the last partial word
	input  logic        burst_idle_i,   // Collector has nothing left
	output logic [5:0]  brightness_o,
	output logic        chroma_en_o,
	output logic [15:0] chroma_key_o
);
	import tmu_pkg::*;

	ctl_state_e       state;
	ctl_state_e       next_state;
	csr_reg_e         reg_sel;
	logic [CNT_W-1:0] pix_count;        // Run length
	logic [CNT_W-1:0] admitted;         // Pixels taken so far
	logic [CNT_W-1:0] retired;          // Pixels consumed by collector
	logic             blk_hit;
	logic             reg_hit;
	logic             wr_en;
	logic             start;
	logic             busy;
	logic [31:0]      rd_data;

	assign blk_hit = (csr_a_i[13:10] == CSR_BLOCK);
	assign reg_hit = blk_hit && (csr_a_i[9:2] == '0);    // Offsets past the map read zero
	assign reg_sel = csr_reg_e'(csr_a_i[1:0]);
	assign wr_en   = csr_we_i && reg_hit;
	assign start   = wr_en && (reg_sel == CTL) && csr_di_i[0];
	assign busy    = (state != IDLE);

	// Register writes
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			brightness_o <= '0;
			chroma_en_o  <= 1'b0;
			chroma_key_o <= '0;
			pix_count    <= '0;
		end else if (wr_en) begin
			case (reg_sel)
				CTL:        chroma_en_o  <= csr_di_i[1];   // Bit 0 is the start strobe
				BRIGHTNESS: brightness_o <= csr_di_i[5:0];
				CHROMA_KEY: chroma_key_o <= csr_di_i[15:0];
				PIX_COUNT:  pix_count    <= csr_di_i[CNT_W-1:0];
				default: ;
			endcase
		end
	end

	// Read mux
	always_comb begin
		rd_data = '0;
		if (reg_hit) begin
			case (reg_sel)
				CTL:        rd_data = {30'd0, chroma_en_o, busy};
				BRIGHTNESS: rd_data = 32'(brightness_o);
				CHROMA_KEY: rd_data = 32'(chroma_key_o);
				PIX_COUNT:  rd_data = 32'(pix_count);
				default:    rd_data = '0;
			endcase
		end
	end

	// Sequencer next state and strobes
	always_comb begin
		next_state = state;
		admit_o    = 1'b0;
		flush_o    = 1'b0;
		case (state)
			IDLE: begin
				if (start)
					next_state = ADMIT;
			end
			ADMIT: begin
				admit_o = (admitted != pix_count);   // Drops once count reached
				if (admitted == pix_count)
					next_state = DRAIN;
			end
			DRAIN: begin
				if (retired == pix_count)
					next_state = FLUSH;
			end
			FLUSH: begin
				flush_o    = 1'b1;                   // Single-cycle pulse
				next_state = WAIT_FLUSH;
			end
			WAIT_FLUSH: begin
				if (burst_idle_i)
					next_state = IDLE;
			end
			default: next_state = IDLE;
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state    <= IDLE;
			admitted <= '0;
			retired  <= '0;
			irq_o    <= 1'b0;
			csr_do_o <= '0;
		end else begin
			state    <= next_state;
			csr_do_o <= rd_data;                     // One cycle read latency
			irq_o    <= (state == WAIT_FLUSH) && burst_idle_i;
			if (state == IDLE && start) begin
				admitted <= '0;                      // New run
				retired  <= '0;
			end else begin
				if (accept_i)
					admitted <= admitted + 1'b1;
				if (retire_i)
					retired <= retired + 1'b1;
			end
		end
	end

endmodule

/* tmu_dispatch.sv */
// Input stage of the pixel back end; hands pixels round-robin to the decay lanes against credits
`timescale 1ns/10ps

module tmu_dispatch (
	input  logic                      sys_clk,
	input  logic                      sys_rst,
	input  logic                      admit_i,        // Run still taking pixels
	output logic                      accept_o,       // Pulse per transfer
	input  logic                      pix_stb_i,
	output logic                      pix_ack_o,
	input  tmu_pkg::pixel_in_t        pix_i,
	output logic [tmu_pkg::LANES-1:0] lane_vld_o,     // One-hot write strobe
	output tmu_pkg::pixel_in_t        lane_pix_o,     // Shared by all lanes
	input  logic [tmu_pkg::LANES-1:0] lane_credit_i   // Lane freed a buffer entry
);
	import tmu_pkg::*;

	logic [LANE_W-1:0]   ptr;                  // Lane that gets the next pixel
	logic [CREDIT_W-1:0] credit [LANES];       // Free entries seen per lane
	logic                xfer;

	// No dependence on pix_stb_i here
	assign pix_ack_o  = admit_i && (credit[ptr] != '0);
	assign xfer       = pix_stb_i && pix_ack_o;
	assign accept_o   = xfer;
	assign lane_pix_o = pix_i;                 // Broadcast, valid picks the lane

	always_comb begin
		lane_vld_o      = '0;
		lane_vld_o[ptr] = xfer;
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			ptr <= '0;
			for (int k = 0; k < LANES; k++)
				credit[k] <= CREDIT_W'(LANE_DEPTH);   // Lane buffers start empty
		end else begin
			if (xfer)
				ptr <= (ptr == LANE_W'(LANES - 1)) ? '0 : ptr + 1'b1;
			for (int k = 0; k < LANES; k++)
				credit[k] <= credit[k] + CREDIT_W'(lane_credit_i[k])
					- CREDIT_W'(lane_vld_o[k]);     // Return and use may coincide
		end
	end

endmodule

/* tmu_decay.sv */
// One decay lane of the pixel back end; buffers credited input and applies chroma key and brightness
`timescale 1ns/10ps

module tmu_decay (
	input  logic                sys_clk,
	input  logic                sys_rst,
	input  logic                vld_i,          // Write strobe from dispatcher
	input  tmu_pkg::pixel_in_t  pix_i,
	output logic                credit_o,       // Entry left the buffer
	input  logic [5:0]          brightness_i,
	input  logic                chroma_en_i,
	input  logic [15:0]         chroma_key_i,
	output logic                vld_o,          // One-cycle result strobe
	output tmu_pkg::pixel_out_t pix_o,
	input  logic                credit_i        // Collector freed a slot
);
	import tmu_pkg::*;

	pixel_in_t            buf_mem [LANE_DEPTH];
	logic [BUF_PTR_W-1:0] wr_ptr;
	logic [BUF_PTR_W-1:0] rd_ptr;
	logic [CREDIT_W-1:0]  fill;                // Occupied entries
	logic [CREDIT_W-1:0]  out_credit;          // Free collector slots
	logic                 pop;
	logic                 s1_vld;
	pixel_in_t            s1_pix;              // Processing register
	logic                 keep;
	logic [5:0]           red_s;
	logic [5:0]           green_s;
	logic [5:0]           blue_s;

	// Channel times (brightness + 1), divided by 64
	function automatic logic [5:0] scale_ch(input logic [5:0] ch, input logic [5:0] br);
		logic [12:0] prod;
		prod = ch * ({1'b0, br} + 7'd1);
		return prod[11:6];
	endfunction

	assign pop      = (fill != '0) && (out_credit != '0);   // Slot reserved downstream
	assign credit_o = pop;
	assign keep     = !(chroma_en_i && (s1_pix.pix == chroma_key_i));
	assign red_s    = scale_ch({1'b0, s1_pix.pix[15:11]}, brightness_i);
	assign green_s  = scale_ch(s1_pix.pix[10:5], brightness_i);
	assign blue_s   = scale_ch({1'b0, s1_pix.pix[4:0]}, brightness_i);

	always_ff @(posedge sys_clk) begin
		if (vld_i)
			buf_mem[wr_ptr] <= pix_i;           // Never full, sender holds credits
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fill       <= '0;
			out_credit <= CREDIT_W'(LANE_DEPTH);
			s1_vld     <= 1'b0;
			vld_o      <= 1'b0;
		end else begin
			if (vld_i)
				wr_ptr <= (wr_ptr == BUF_PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == BUF_PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			fill       <= fill + CREDIT_W'(vld_i) - CREDIT_W'(pop);
			out_credit <= out_credit + CREDIT_W'(credit_i) - CREDIT_W'(pop);
			s1_vld     <= pop;
			vld_o      <= s1_vld;                // Pipeline never stalls
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pop)
			s1_pix <= buf_mem[rd_ptr];
		if (s1_vld) begin
			pix_o.keep <= keep;
			pix_o.pix  <= {red_s[4:0], green_s, blue_s[4:0]};   // Repack RGB565
			pix_o.addr <= s1_pix.addr;
		end
	end

endmodule

/* tmu_burst.sv */
// Collector of the pixel back end; drains lanes in order, merges pixels into words, writes memory
`timescale 1ns/10ps

module tmu_burst (
	input  logic                                      sys_clk,
	input  logic                                      sys_rst,
	input  logic [tmu_pkg::LANES-1:0]                 lane_vld_i,
	input  tmu_pkg::pixel_out_t [tmu_pkg::LANES-1:0]  lane_pix_i,
	output logic [tmu_pkg::LANES-1:0]                 lane_credit_o,  // Slot freed per lane
	output logic                                      retire_o,       // Pixel consumed
	input  logic                                      flush_i,
	output logic                                      idle_o,
	output logic                                      mem_stb_o,
	input  logic                                      mem_ack_i,
	output tmu_pkg::mem_wr_t                          mem_o
);
	import tmu_pkg::*;

	pixel_out_t             buf_mem [LANES][LANE_DEPTH];
	logic [BUF_PTR_W-1:0]   wr_ptr [LANES];
	logic [BUF_PTR_W-1:0]   rd_ptr [LANES];
	logic [CREDIT_W-1:0]    fill [LANES];
	logic [LANE_W-1:0]      lane_sel;        // Lane expected next, keeps order
	pixel_out_t             head;
	logic                   head_vld;
	logic [WORD_ADDR_W-1:0] head_word;
	logic [1:0]             head_slot;
	logic [WORD_ADDR_W-1:0] cur_addr;        // Word being assembled
	logic [7:0]             cur_sel;
	logic [63:0]            cur_data;
	logic [7:0]             next_sel;
	logic [63:0]            next_data;
	logic                   addr_change;
	logic                   wr_free;
	logic                   consume;
	logic                   flush_req;
	logic                   flush_pend;      // Flush waiting for the write register
	logic                   move_cur;

	assign head        = buf_mem[lane_sel][rd_ptr[lane_sel]];
	assign head_vld    = (fill[lane_sel] != '0);
	assign head_word   = head.addr[ADDR_W-1:2];
	assign head_slot   = head.addr[1:0];
	assign wr_free     = !mem_stb_o || mem_ack_i;                   // Free now or this edge
	assign addr_change = head.keep && (cur_sel != '0) && (cur_addr != head_word);
	assign consume     = head_vld && (!addr_change || wr_free);
	assign flush_req   = flush_i || flush_pend;
	assign move_cur    = (consume && addr_change)
		|| (!consume && flush_req && (cur_sel != '0) && wr_free);
	assign retire_o    = consume;
	assign idle_o      = (cur_sel == '0) && !mem_stb_o;

	always_comb begin
		lane_credit_o           = '0;
		lane_credit_o[lane_sel] = consume;
	end

	// Merge head pixel into the current or a fresh word
	always_comb begin
		next_sel  = addr_change ? 8'd0 : cur_sel;
		next_data = (addr_change || cur_sel == '0) ? 64'd0 : cur_data;
		next_sel  = next_sel | (8'b11 << {head_slot, 1'b0});          // Two bytes per slot
		next_data[{head_slot, 4'b0} +: 16] = head.pix;                 // Later pixel wins
	end

	always_ff @(posedge sys_clk) begin
		for (int k = 0; k < LANES; k++)
			if (lane_vld_i[k])
				buf_mem[k][wr_ptr[k]] <= lane_pix_i[k];
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			for (int k = 0; k < LANES; k++) begin
				wr_ptr[k] <= '0;
				rd_ptr[k] <= '0;
				fill[k]   <= '0;
			end
			lane_sel   <= '0;
			cur_sel    <= '0;
			flush_pend <= 1'b0;
			mem_stb_o  <= 1'b0;
		end else begin
			for (int k = 0; k < LANES; k++) begin
				if (lane_vld_i[k])
					wr_ptr[k] <= (wr_ptr[k] == BUF_PTR_W'(LANE_DEPTH - 1)) ? '0 : wr_ptr[k] + 1'b1;
				if (lane_credit_o[k])
					rd_ptr[k] <= (rd_ptr[k] == BUF_PTR_W'(LANE_DEPTH - 1)) ? '0 : rd_ptr[k] + 1'b1;
				fill[k] <= fill[k] + CREDIT_W'(lane_vld_i[k]) - CREDIT_W'(lane_credit_o[k]);
			end
			if (consume)
				lane_sel <= (lane_sel == LANE_W'(LANES - 1)) ? '0 : lane_sel + 1'b1;
			if (consume && head.keep)
				cur_sel <= next_sel;
			else if (move_cur)
				cur_sel <= '0;                   // Flushed out
			flush_pend <= flush_req && (cur_sel != '0) && !move_cur;
			if (move_cur)
				mem_stb_o <= 1'b1;
			else if (mem_ack_i)
				mem_stb_o <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (consume && head.keep) begin
			cur_addr <= head_word;
			cur_data <= next_data;
		end
		if (move_cur)
			mem_o <= '{addr: cur_addr, sel: cur_sel, data: cur_data};   // Held until ack
	end

endmodule

/* tmu.sv */
// Top of the texture mapping pixel back end; CSR block, dispatcher, decay lanes and collector
`timescale 1ns/10ps

module tmu (
	input  logic               sys_clk,
	input  logic               sys_rst,
	input  logic [13:0]        csr_a_i,
	input  logic               csr_we_i,
	input  logic [31:0]        csr_di_i,
	output logic [31:0]        csr_do_o,
	output logic               irq_o,
	input  logic               pix_stb_i,     // Source texel stream
	output logic               pix_ack_o,
	input  tmu_pkg::pixel_in_t pix_i,
	output logic               mem_stb_o,     // Framebuffer write port
	input  logic               mem_ack_i,
	output tmu_pkg::mem_wr_t   mem_o
);
	import tmu_pkg::*;

	logic                    admit;
	logic                    accept;
	logic                    retire;
	logic                    flush;
	logic                    burst_idle;
	logic [5:0]              brightness;
	logic                    chroma_en;
	logic [15:0]             chroma_key;
	logic [LANES-1:0]        disp_vld;      // Dispatcher to lanes
	logic [LANES-1:0]        disp_credit;   // Lanes back to dispatcher
	pixel_in_t               disp_pix;
	logic [LANES-1:0]        lane_vld;      // Lanes to collector
	logic [LANES-1:0]        lane_credit;   // Collector back to lanes
	pixel_out_t [LANES-1:0]  lane_pix;

	tmu_ctlif u_ctlif (
		.sys_clk      (sys_clk),
		.sys_rst      (sys_rst),
		.csr_a_i      (csr_a_i),
		.csr_we_i     (csr_we_i),
		.csr_di_i     (csr_di_i),
		.csr_do_o     (csr_do_o),
		.irq_o        (irq_o),
		.admit_o      (admit),
		.accept_i     (accept),
		.retire_i     (retire),
		.flush_o      (flush),
		.burst_idle_i (burst_idle),
		.brightness_o (brightness),
		.chroma_en_o  (chroma_en),
		.chroma_key_o (chroma_key)
	);

	tmu_dispatch u_dispatch (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.admit_i       (admit),
		.accept_o      (accept),
		.pix_stb_i     (pix_stb_i),
		.pix_ack_o     (pix_ack_o),
		.pix_i         (pix_i),
		.lane_vld_o    (disp_vld),
		.lane_pix_o    (disp_pix),
		.lane_credit_i (disp_credit)
	);

	for (genvar g = 0; g < LANES; g++) begin : g_lane
		tmu_decay u_decay (
			.sys_clk      (sys_clk),
			.sys_rst      (sys_rst),
			.vld_i        (disp_vld[g]),
			.pix_i        (disp_pix),
			.credit_o     (disp_credit[g]),
			.brightness_i (brightness),
			.chroma_en_i  (chroma_en),
			.chroma_key_i (chroma_key),
			.vld_o        (lane_vld[g]),
			.pix_o        (lane_pix[g]),
			.credit_i     (lane_credit[g])
		);
	end

	tmu_burst u_burst (
		.sys_clk       (sys_clk),
		.sys_rst       (sys_rst),
		.lane_vld_i    (lane_vld),
		.lane_pix_i    (lane_pix),
		.lane_credit_o (lane_credit),
		.retire_o      (retire),
		.flush_i       (flush),
		.idle_o        (burst_idle),
		.mem_stb_o     (mem_stb_o),
		.mem_ack_i     (mem_ack_i),
		.mem_o         (mem_o)
	);

endmodule

/* tmu_assertions.sv */
// Protocol checks on the write port, irq and reset values of the pixel back end; bound into tmu
`timescale 1ns/10ps

module tmu_assertions (
	input logic             sys_clk,
	input logic             sys_rst,
	input logic             mem_stb_i,
	input logic             mem_ack_i,
	input tmu_pkg::mem_wr_t mem_i,
	input logic             irq_i,
	input logic             pix_ack_i
);
	int fail_count = 0;                         // Failed checks so far

	// Request and payload frozen until the ack cycle
	a_mem_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_stb_i && !mem_ack_i |=> mem_stb_i && $stable(mem_i))
	else begin
		fail_count++;
		$error("write request or payload changed before acknowledge");
	end

	a_mem_sel: assert property (@(posedge sys_clk) disable iff (sys_rst)
		mem_stb_i |-> (mem_i.sel != '0))       // Empty words are never written
	else begin
		fail_count++;
		$error("write request with an empty byte select");
	end

	a_irq_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		irq_i |=> !irq_i)                      // Single-cycle irq
	else begin
		fail_count++;
		$error("irq held for more than one cycle");
	end

	a_rst_quiet: assert property (@(posedge sys_clk)
		$fell(sys_rst) |-> !pix_ack_i && !mem_stb_i)
	else begin
		fail_count++;
		$error("handshake outputs active right after reset");
	end

endmodule

bind tmu tmu_assertions u_assertions (
	.sys_clk   (sys_clk),
	.sys_rst   (sys_rst),
	.mem_stb_i (mem_stb_o),
	.mem_ack_i (mem_ack_i),
	.mem_i     (mem_o),
	.irq_i     (irq_o),
	.pix_ack_i (pix_ack_o)
);

/* tb_tmu.sv */
// Directed testbench for the pixel back end; compile with tmu.f and run tb_tmu as top
`timescale 1ns/10ps

module tb_tmu;
	import tmu_pkg::*;

	localparam int TIMEOUT = 2000;              // Cycles allowed per wait loop

	logic                   sys_clk;
	logic                   sys_rst;
	logic [13:0]            csr_a_i;
	logic                   csr_we_i;
	logic [31:0]            csr_di_i;
	logic [31:0]            csr_do_o;
	logic                   irq_o;
	logic                   pix_stb_i;
	logic                   pix_ack_o;
	pixel_in_t              pix_i;
	logic                   mem_stb_o;
	logic                   mem_ack_i;
	mem_wr_t                mem_o;

	mem_wr_t                act_q[$];           // Writes seen on the port
	mem_wr_t                exp_q[$];           // Writes built by the model
	logic [31:0]            pix_rng;            // Stimulus generator state
	logic [31:0]            ack_rng;            // Ack delay generator state
	logic                   ack_rand;           // Random ack delays when set
	int                     ack_wait;
	int                     irq_count;
	int                     irq_before;
	logic [5:0]             cfg_br;             // Settings of the current run
	logic                   cfg_en;
	logic [15:0]            cfg_key;
	logic [WORD_ADDR_W-1:0] m_addr;             // Model's word under assembly
	logic [7:0]             m_sel;
	logic [63:0]            m_data;

	tmu u_dut (
		.sys_clk   (sys_clk),
		.sys_rst   (sys_rst),
		.csr_a_i   (csr_a_i),
		.csr_we_i  (csr_we_i),
		.csr_di_i  (csr_di_i),
		.csr_do_o  (csr_do_o),
		.irq_o     (irq_o),
		.pix_stb_i (pix_stb_i),
		.pix_ack_o (pix_ack_o),
		.pix_i     (pix_i),
		.mem_stb_o (mem_stb_o),
		.mem_ack_i (mem_ack_i),
		.mem_o     (mem_o)
	);

	always #10 sys_clk = ~sys_clk;              // 20 ns period

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// Each channel times (brightness + 1), over 64
	function automatic logic [15:0] decay_pix(input logic [15:0] p, input logic [5:0] br);
		int f;
		int r;
		int g;
		int b;
		f = int'(br) + 1;
		r = (int'(p[15:11]) * f) >> 6;
		g = (int'(p[10:5]) * f) >> 6;
		b = (int'(p[4:0]) * f) >> 6;
		return {r[4:0], g[5:0], b[4:0]};
	endfunction

	function automatic logic [13:0] reg_addr(input csr_reg_e r);
		return {CSR_BLOCK, 8'h00, 2'(r)};
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
		if (got !== exp)
			abort_run($sformatf("[ERROR] %s got %0h expected %0h", name, got, exp));
	endtask

	// Merge rule of the collector, word by word
	task automatic model_pixel(input pixel_in_t p);
		logic [WORD_ADDR_W-1:0] w;
		int                     s;
		w = p.addr[ADDR_W-1:2];
		s = p.addr[1:0];
		if (!(cfg_en && p.pix == cfg_key)) begin  // Keyed pixels leave no trace
			if (m_sel != '0 && m_addr != w) begin
				exp_q.push_back('{addr: m_addr, sel: m_sel, data: m_data});
				m_sel = '0;
			end
			if (m_sel == '0)
				m_data = '0;
			m_addr             = w;
			m_sel[2*s +: 2]    = 2'b11;
			m_data[16*s +: 16] = decay_pix(p.pix, cfg_br);  // Later pixel in a slot wins
		end
	endtask

	task automatic model_flush();
		if (m_sel != '0)
			exp_q.push_back('{addr: m_addr, sel: m_sel, data: m_data});
		m_sel = '0;
	endtask

	task automatic csr_write(input csr_reg_e r, input logic [31:0] d);
		csr_a_i  = reg_addr(r);
		csr_di_i = d;
		csr_we_i = 1'b1;
		@(negedge sys_clk);
		csr_we_i = 1'b0;
	endtask

	task automatic csr_read(input logic [13:0] a, output logic [31:0] d);
		csr_a_i  = a;
		csr_we_i = 1'b0;
		@(negedge sys_clk);
		d = csr_do_o;                           // Registered, one cycle later
	endtask

	task automatic send_pixel(input logic [15:0] pix, input logic [ADDR_W-1:0] addr);
		int n;
		n         = 0;
		pix_i     = '{pix: pix, addr: addr};
		pix_stb_i = 1'b1;
		while (!pix_ack_o) begin                // Ack does not look at the strobe
			@(negedge sys_clk);
			n++;
			if (n > TIMEOUT)
				abort_run("pixel was never acknowledged");
		end
		@(negedge sys_clk);
		pix_stb_i = 1'b0;
		model_pixel(pix_i);
	endtask

	task automatic start_run(input logic [5:0] br, input logic en, input logic [15:0] key,
			input int count);
		cfg_br     = br;
		cfg_en     = en;
		cfg_key    = key;
		m_sel      = '0;
		irq_before = irq_count;
		act_q.delete();
		exp_q.delete();
		csr_write(BRIGHTNESS, 32'(br));
		csr_write(CHROMA_KEY, 32'(key));
		csr_write(PIX_COUNT, 32'(count));
		csr_write(CTL, {30'd0, en, 1'b1});      // Start with key enable
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (!irq_o) begin
			@(negedge sys_clk);
			n++;
			if (n > TIMEOUT)
				abort_run("irq did not arrive at the end of the run");
		end
		@(negedge sys_clk);                     // Let the monitor count it
	endtask

	task automatic wait_writes(input int count);
		int n;
		n = 0;
		while (act_q.size() < count) begin
			@(negedge sys_clk);
			n++;
			if (n > TIMEOUT)
				abort_run("expected framebuffer writes did not appear");
		end
	endtask

	task automatic finish_run();
		logic [31:0] d;
		wait_irq();
		model_flush();
		check_val("irq pulses", irq_count - irq_before, 1);
		check_val("write count", act_q.size(), exp_q.size());
		for (int i = 0; i < exp_q.size(); i++) begin
			check_val("mem_o.addr", act_q[i].addr, exp_q[i].addr);
			check_val("mem_o.sel", act_q[i].sel, exp_q[i].sel);
			check_val("mem_o.data", act_q[i].data, exp_q[i].data);
		end
		csr_read(reg_addr(CTL), d);
		check_val("busy", d[0], 1'b0);
	endtask

	task automatic test_csr();
		logic [31:0] d;
		csr_read(reg_addr(CTL), d);
		check_val("busy", d[0], 1'b0);
		csr_write(BRIGHTNESS, 32'h2a);
		csr_write(CHROMA_KEY, 32'hbeef);
		csr_write(PIX_COUNT, 32'habcde);
		csr_write(CTL, 32'h2);                  // Key enable without start
		csr_read(reg_addr(BRIGHTNESS), d);
		check_val("BRIGHTNESS", d, 32'h2a);
		csr_read(reg_addr(CHROMA_KEY), d);
		check_val("CHROMA_KEY", d, 32'hbeef);
		csr_read(reg_addr(PIX_COUNT), d);
		check_val("PIX_COUNT", d, 32'habcde);
		csr_read(reg_addr(CTL), d);
		check_val("CTL", d, 32'h2);
		csr_read({~CSR_BLOCK, 10'h001}, d);     // Other block reads zero
		check_val("csr_do_o", d, 32'h0);
		csr_write(CTL, 32'h0);
	endtask

	task automatic test_brightness();
		start_run(6'd63, 1'b0, 16'h0, 4);      // Full brightness passes through
		send_pixel(16'h1111, 24'h100);
		send_pixel(16'h2222, 24'h101);
		send_pixel(16'h3333, 24'h102);
		send_pixel(16'h4444, 24'h103);
		finish_run();
		check_val("mem_o.sel", act_q[0].sel, 8'hff);
		check_val("mem_o.data", act_q[0].data, 64'h4444_3333_2222_1111);
		start_run(6'd31, 1'b0, 16'h0, 4);      // Half brightness
		for (int i = 0; i < 4; i++)
			send_pixel(16'hffff, ADDR_W'(32'h200 + i));
		finish_run();
		check_val("mem_o.data", act_q[0].data, {4{16'h7bef}});
	endtask

	task automatic test_chroma();
		for (int en = 1; en >= 0; en--) begin
			start_run(6'd63, en[0], 16'h07e0, 4);
			send_pixel(16'hf800, 24'h300);
			send_pixel(16'h07e0, 24'h301);      // Matches the key
			send_pixel(16'h001f, 24'h302);
			send_pixel(16'h07e0, 24'h303);
			finish_run();
			check_val("mem_o.sel", act_q[0].sel, en ? 8'h33 : 8'hff);
		end
	endtask

	task automatic test_merge();
		logic [31:0] d;
		start_run(6'd47, 1'b0, 16'h0, 6);
		send_pixel(16'h1234, 24'h013);
		send_pixel(16'h5678, 24'h011);
		send_pixel(16'h9abc, 24'h011);          // Same slot again
		send_pixel(16'hdef0, 24'h02a);
		send_pixel(16'h0f0f, 24'h008);          // Back to a lower word
		wait_writes(2);                         // Words 0x004 and 0x00a are out
		csr_read(reg_addr(CTL), d);             // Word 0x002 stays open mid-run
		check_val("busy", d[0], 1'b1);
		check_val("write count", act_q.size(), 2);
		send_pixel(16'hf0f0, 24'h009);
		finish_run();
		check_val("write count", act_q.size(), 3);
		start_run(6'd0, 1'b0, 16'h0, 0);       // Empty run still ends in irq
		finish_run();
	endtask

	task automatic test_random();
		logic [31:0] r;
		ack_rand = 1'b1;
		start_run(6'd40, 1'b1, 16'h1234, 64);
		for (int i = 0; i < 64; i++) begin
			pix_rng = xorshift(pix_rng);
			r       = pix_rng;
			send_pixel((r[3:0] == 4'h0) ? 16'h1234 : r[31:16], ADDR_W'(32'h400 + r[8:4]));
		end
		check_val("pix_ack_o", pix_ack_o, 1'b0); // Count reached
		finish_run();
		ack_rand = 1'b0;
	endtask

	// Write and irq monitor
	always @(posedge sys_clk) begin
		if (!sys_rst && mem_stb_o && mem_ack_i)
			act_q.push_back(mem_o);
		if (!sys_rst && irq_o)
			irq_count++;
	end

	// Memory ack, immediate or after 0 to 3 cycles
	always @(negedge sys_clk) begin
		if (!ack_rand) begin
			mem_ack_i = 1'b1;
		end else if (mem_stb_o && !mem_ack_i) begin
			if (ack_wait == 0)
				mem_ack_i = 1'b1;
			else
				ack_wait--;
		end else begin
			mem_ack_i = 1'b0;
			ack_rng   = xorshift(ack_rng);
			ack_wait  = ack_rng % 4;
		end
	end

	always @(negedge sys_clk)
		if (u_dut.u_assertions.fail_count != 0)
			abort_run("a protocol assertion on the DUT failed");

	initial begin
		sys_clk   = 1'b0;
		sys_rst   = 1'b1;
		csr_a_i   = '0;
		csr_we_i  = 1'b0;
		csr_di_i  = '0;
		pix_stb_i = 1'b0;
		pix_i     = '0;
		mem_ack_i = 1'b1;
		ack_rand  = 1'b0;
		ack_wait  = 0;
		pix_rng   = 32'h9b54;
		ack_rng   = 32'h9b54;
		irq_count = 0;
		m_sel     = '0;
		repeat (3) @(posedge sys_clk);
		@(negedge sys_clk);
		sys_rst = 1'b0;
		test_csr();
		test_brightness();
		test_chroma();
		test_merge();
		test_random();
		if (u_dut.u_assertions.fail_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			abort_run("protocol assertions reported failures");
		end
	end

endmodule

/* tmu.f */
tmu_pkg.sv
tmu_ctlif.sv
tmu_dispatch.sv
tmu_decay.sv
tmu_burst.sv
tmu.sv
tmu_assertions.sv
tb_tmu.sv
